// File: source/team_01_consts.svh
// Constants for the team 01 user area
// Slave base address, register byte offsets, count width, GPIO count
`ifndef TEAM_01_CONSTS_SVH
`define TEAM_01_CONSTS_SVH

// Slave window on the management Wishbone bus
`define TEAM01_BASE 32'h3000_0000

// Register byte offsets inside the 32-byte window
`define TEAM01_REG_CTRL 5'h00 // start, fill, irq enable
`define TEAM01_REG_SRC  5'h04 // Source byte address
`define TEAM01_REG_DST  5'h08 // Destination byte address
`define TEAM01_REG_LEN  5'h0C // Words to move
`define TEAM01_REG_PAT  5'h10 // Fill pattern
`define TEAM01_REG_STAT 5'h14 // busy, sticky done
`define TEAM01_REG_CNT  5'h18 // Words written so far

// Word count width
`define TEAM01_LEN_W 16

// Caravel user GPIO pins
`define TEAM01_GPIO_W 38

`endif

// File: source/wb_pkg.sv
// Wishbone bus types
// Address, data and select vectors plus request and response bundles

package wb_pkg;

    typedef logic [31:0] wb_adr_t; // Byte address
    typedef logic [31:0] wb_dat_t; // One bus word
    typedef logic [3:0]  wb_sel_t; // Byte lane enables

    // Master to slave
    typedef struct packed {
        wb_adr_t adr;
        wb_dat_t dat;  // Write data
        wb_sel_t sel;
        logic    we;   // 1 = write
        logic    stb;
        logic    cyc;
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        wb_dat_t dat;  // Read data, valid with ack
        logic    ack;
    } wb_rsp_t;

endpackage

// File: source/xfer_pkg.sv
// Transfer engine types
// Configuration bundle, word count and engine FSM states
`include "team_01_consts.svh"

package xfer_pkg;

    // Number of words in one block transfer
    typedef logic [`TEAM01_LEN_W-1:0] word_count_t;

    // Everything the engine latches on start
    typedef struct packed {
        wb_pkg::wb_adr_t src;   // First source word
        wb_pkg::wb_adr_t dst;   // First destination word
        word_count_t     len;
        wb_pkg::wb_dat_t pat;   // Only used in fill mode
        logic            fill;  // 1 = fill, 0 = copy
    } xfer_cfg_t;

    // Engine FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for start
        READ,   // Source read on the bus
        WRITE,  // Destination write on the bus
        DONE    // One-cycle completion
    } xfer_state_e;

endpackage

// File: source/team_01.sv
// Block transfer engine
// Copies words from src to dst, or fills dst with a pattern,
// through the Wishbone master port, one word at a time
`timescale 1ns/1ns

module team_01 (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  start_i,   // One-cycle pulse from the bus wrapper
    input  xfer_pkg::xfer_cfg_t   cfg_i,     // Sampled with start_i
    output logic                  busy_o,
    output logic                  done_o,    // Pulse after the last write ack
    output xfer_pkg::word_count_t cnt_o,     // Words written
    output wb_pkg::wb_req_t       mst_req_o,
    input  wb_pkg::wb_rsp_t       mst_rsp_i
);

    localparam wb_pkg::wb_adr_t adr_step = 32'd4; // One word per beat

    xfer_pkg::xfer_state_e state_q;
    xfer_pkg::xfer_state_e state_d;
    xfer_pkg::xfer_cfg_t   cfg_q;      // Working copy, addresses advance
    wb_pkg::wb_dat_t       data_q;     // Read word waiting for its write
    xfer_pkg::word_count_t cnt_q;
    logic                  ack;
    logic                  accept;     // Start taken this cycle
    logic                  last_word;  // Current write is the final one

    assign ack = mst_rsp_i.ack;

    // Start is honoured from IDLE and from the DONE cycle
    assign accept = start_i && (state_q == xfer_pkg::IDLE || state_q == xfer_pkg::DONE);

    assign last_word = (cnt_q + xfer_pkg::word_count_t'(1)) == cfg_q.len;

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            xfer_pkg::IDLE, xfer_pkg::DONE: begin
                if (accept) begin
                    if (cfg_i.len == '0) begin
                        state_d = xfer_pkg::DONE;   // Nothing to move
                    end else if (cfg_i.fill) begin
                        state_d = xfer_pkg::WRITE;  // Fill skips the source
                    end else begin
                        state_d = xfer_pkg::READ;
                    end
                end else begin
                    state_d = xfer_pkg::IDLE;
                end
            end
            xfer_pkg::READ: begin
                if (ack) begin
                    state_d = xfer_pkg::WRITE;
                end
            end
            xfer_pkg::WRITE: begin
                if (ack) begin
                    if (last_word) begin
                        state_d = xfer_pkg::DONE;
                    end else if (cfg_q.fill) begin
                        state_d = xfer_pkg::WRITE;
                    end else begin
                        state_d = xfer_pkg::READ;
                    end
                end
            end
            default: state_d = xfer_pkg::IDLE;
        endcase
    end

    // FSM and word counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= xfer_pkg::IDLE;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                cnt_q <= '0;                                   // New run
            end else if (state_q == xfer_pkg::WRITE && ack) begin
                cnt_q <= cnt_q + xfer_pkg::word_count_t'(1);
            end
        end
    end

    // Configuration copy and read data
    always_ff @(posedge clk_i) begin
        if (accept) begin
            cfg_q <= cfg_i;
        end else if (ack) begin
            case (state_q)
                xfer_pkg::READ: begin
                    data_q    <= mst_rsp_i.dat;          // Keep for the write
                    cfg_q.src <= cfg_q.src + adr_step;
                end
                xfer_pkg::WRITE: cfg_q.dst <= cfg_q.dst + adr_step;
                default: ;
            endcase
        end
    end

    // Master request, held by the state until ack
    always_comb begin
        mst_req_o     = '0;
        mst_req_o.sel = '1;  // Whole words only
        case (state_q)
            xfer_pkg::READ: begin
                mst_req_o.adr = cfg_q.src;
                mst_req_o.stb = 1'b1;
                mst_req_o.cyc = 1'b1;
            end
            xfer_pkg::WRITE: begin
                mst_req_o.adr = cfg_q.dst;
                mst_req_o.dat = cfg_q.fill ? cfg_q.pat : data_q;
                mst_req_o.we  = 1'b1;
                mst_req_o.stb = 1'b1;
                mst_req_o.cyc = 1'b1;
            end
            default: ;
        endcase
    end

    assign busy_o = (state_q == xfer_pkg::READ) || (state_q == xfer_pkg::WRITE);
    assign done_o = (state_q == xfer_pkg::DONE);
    assign cnt_o  = cnt_q;

endmodule

// File: source/team_01_wb.sv
// Wishbone slave wrapper around the transfer engine
// Register file with byte enables, start pulse, sticky done,
// status pins and interrupt
`timescale 1ns/1ns
`include "team_01_consts.svh"

module team_01_wb (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  wb_pkg::wb_req_t             wbs_req_i,
    output wb_pkg::wb_rsp_t             wbs_rsp_o,
    output logic [127:0]                la_data_o,
    output logic [`TEAM01_GPIO_W-5:0]   gpio_o,      // GPIO 37:5 and 0
    output logic [`TEAM01_GPIO_W-5:0]   gpio_oeb_o,  // Active low
    output logic                        irq_o,
    output wb_pkg::wb_req_t             mst_req_o,
    input  wb_pkg::wb_rsp_t             mst_rsp_i
);

    localparam wb_pkg::wb_adr_t base_adr = `TEAM01_BASE;
    localparam int unsigned     win_bits = 5;  // 32-byte register window

    logic [win_bits-1:0]   ofs;
    logic                  hit;       // Addressed cycle
    logic                  acc;       // Access taken this cycle
    logic                  wr;
    logic                  ack_q;
    wb_pkg::wb_dat_t       rdata;     // Current value of the addressed register
    wb_pkg::wb_dat_t       wdata;     // Same value with the write bytes merged in
    wb_pkg::wb_dat_t       rdata_q;
    wb_pkg::wb_adr_t       src_q;
    wb_pkg::wb_adr_t       dst_q;
    xfer_pkg::word_count_t len_q;
    wb_pkg::wb_dat_t       pat_q;
    logic                  fill_q;
    logic                  irq_en_q;
    logic                  done_q;    // Sticky
    logic                  start_q;   // One-cycle start to the core
    logic                  busy;
    logic                  done;
    xfer_pkg::word_count_t cnt;
    xfer_pkg::xfer_cfg_t   cfg;

    // Lane-wise merge of a write into an old word
    function automatic wb_pkg::wb_dat_t merge_bytes(input wb_pkg::wb_dat_t old_val,
                                                    input wb_pkg::wb_dat_t new_val,
                                                    input wb_pkg::wb_sel_t sel);
        wb_pkg::wb_dat_t res;
        res = old_val;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) begin
                res[8*i +: 8] = new_val[8*i +: 8];
            end
        end
        return res;
    endfunction

    assign ofs = wbs_req_i.adr[win_bits-1:0];
    assign hit = wbs_req_i.cyc && wbs_req_i.stb &&
                 (wbs_req_i.adr[31:win_bits] == base_adr[31:win_bits]);
    assign acc = hit && !ack_q;  // One ack per strobe
    assign wr  = acc && wbs_req_i.we;

    // Read mux with zero for unmapped offsets
    always_comb begin
        rdata = '0;
        case (ofs)
            `TEAM01_REG_CTRL: rdata[2:1] = {irq_en_q, fill_q};  // Start reads 0
            `TEAM01_REG_SRC:  rdata = src_q;
            `TEAM01_REG_DST:  rdata = dst_q;
            `TEAM01_REG_LEN:  rdata = wb_pkg::wb_dat_t'(len_q);
            `TEAM01_REG_PAT:  rdata = pat_q;
            `TEAM01_REG_STAT: rdata[1:0] = {done_q, busy};
            `TEAM01_REG_CNT:  rdata = wb_pkg::wb_dat_t'(cnt);
            default:          rdata = '0;
        endcase
    end

    assign wdata = merge_bytes(rdata, wbs_req_i.dat, wbs_req_i.sel);

    // Control registers and bus handshake
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q    <= 1'b0;
            src_q    <= '0;
            dst_q    <= '0;
            len_q    <= '0;
            pat_q    <= '0;
            fill_q   <= 1'b0;
            irq_en_q <= 1'b0;
            done_q   <= 1'b0;
            start_q  <= 1'b0;
        end else begin
            ack_q   <= acc;
            start_q <= 1'b0;
            if (wr) begin
                case (ofs)
                    `TEAM01_REG_CTRL: begin
                        fill_q   <= wdata[1];
                        irq_en_q <= wdata[2];
                        start_q  <= wdata[0] && !busy;  // Dropped while busy
                    end
                    `TEAM01_REG_SRC: src_q <= wdata;
                    `TEAM01_REG_DST: dst_q <= wdata;
                    `TEAM01_REG_LEN: len_q <= xfer_pkg::word_count_t'(wdata);
                    `TEAM01_REG_PAT: pat_q <= wdata;
                    default: ;  // STAT and CNT are read only
                endcase
            end
            if (start_q) begin
                done_q <= 1'b0;  // New run clears it
            end else if (done) begin
                done_q <= 1'b1;
            end
        end
    end

    // Read data valid in the ack cycle
    always_ff @(posedge clk_i) begin
        if (acc) begin
            rdata_q <= rdata;
        end
    end

    assign wbs_rsp_o = '{dat: rdata_q, ack: ack_q};

    assign cfg = '{src: src_q, dst: dst_q, len: len_q, pat: pat_q, fill: fill_q};

    team_01 core (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (start_q),
        .cfg_i     (cfg),
        .busy_o    (busy),
        .done_o    (done),
        .cnt_o     (cnt),
        .mst_req_o (mst_req_o),
        .mst_rsp_i (mst_rsp_i)
    );

    // Pin 0 drives busy and the rest stay inputs
    assign gpio_o     = {{(`TEAM01_GPIO_W-5){1'b0}}, busy};
    assign gpio_oeb_o = {{(`TEAM01_GPIO_W-5){1'b1}}, 1'b0};
    assign la_data_o  = {{(128-`TEAM01_LEN_W){1'b0}}, cnt};  // Progress on LA 15:0
    assign irq_o      = done_q && irq_en_q;

endmodule

// File: source/team_01_wrapper.sv
// Chip-facing top of the team 01 user area
// Pin bundling, GPIO 4:1 and IRQ tie-offs, bus wrapper instance
`timescale 1ns/1ns
`include "team_01_consts.svh"

module team_01_wrapper (
    input  logic                      wb_clk_i,
    input  logic                      rst_i,
    input  logic                      wbs_stb_i,   // Management slave port
    input  logic                      wbs_cyc_i,
    input  logic                      wbs_we_i,
    input  wb_pkg::wb_sel_t           wbs_sel_i,
    input  wb_pkg::wb_dat_t           wbs_dat_i,
    input  wb_pkg::wb_adr_t           wbs_adr_i,
    output logic                      wbs_ack_o,
    output wb_pkg::wb_dat_t           wbs_dat_o,
    input  logic [127:0]              la_data_i,
    output logic [127:0]              la_data_o,
    input  logic [127:0]              la_oenb_i,
    input  logic [`TEAM01_GPIO_W-1:0] gpio_i,
    output logic [`TEAM01_GPIO_W-1:0] gpio_o,
    output logic [`TEAM01_GPIO_W-1:0] gpio_oeb_o,  // Active low
    output logic [2:0]                irq_o,
    input  wb_pkg::wb_dat_t           mst_dat_i,   // Engine master port
    input  logic                      mst_ack_i,
    output wb_pkg::wb_adr_t           mst_adr_o,
    output wb_pkg::wb_dat_t           mst_dat_o,
    output wb_pkg::wb_sel_t           mst_sel_o,
    output logic                      mst_we_o,
    output logic                      mst_stb_o,
    output logic                      mst_cyc_o
);

    wb_pkg::wb_req_t                 wbs_req;
    wb_pkg::wb_rsp_t                 wbs_rsp;
    wb_pkg::wb_req_t                 mst_req;
    wb_pkg::wb_rsp_t                 mst_rsp;
    logic [`TEAM01_GPIO_W-5:0]       gpio_out;  // Pins 37:5 and 0
    logic [`TEAM01_GPIO_W-5:0]       gpio_oeb;
    logic                            irq;

    assign wbs_req = '{adr: wbs_adr_i, dat: wbs_dat_i, sel: wbs_sel_i,
                       we: wbs_we_i, stb: wbs_stb_i, cyc: wbs_cyc_i};
    assign wbs_ack_o = wbs_rsp.ack;
    assign wbs_dat_o = wbs_rsp.dat;

    assign mst_rsp   = '{dat: mst_dat_i, ack: mst_ack_i};
    assign mst_adr_o = mst_req.adr;
    assign mst_dat_o = mst_req.dat;
    assign mst_sel_o = mst_req.sel;
    assign mst_we_o  = mst_req.we;
    assign mst_stb_o = mst_req.stb;
    assign mst_cyc_o = mst_req.cyc;

    // GPIO 4:1 reserved, kept as inputs
    assign gpio_o     = {gpio_out[`TEAM01_GPIO_W-5:1], 4'b0000, gpio_out[0]};
    assign gpio_oeb_o = {gpio_oeb[`TEAM01_GPIO_W-5:1], 4'b1111, gpio_oeb[0]};
    assign irq_o      = {2'b00, irq};  // Only line 0 in use

    team_01_wb team_01_wb (
        .clk_i      (wb_clk_i),
        .rst_i      (rst_i),
        .wbs_req_i  (wbs_req),
        .wbs_rsp_o  (wbs_rsp),
        .la_data_o  (la_data_o),
        .gpio_o     (gpio_out),
        .gpio_oeb_o (gpio_oeb),
        .irq_o      (irq),
        .mst_req_o  (mst_req),
        .mst_rsp_i  (mst_rsp)
    );

endmodule

// File: verification/team_01_sva.sv
// Concurrent assertions on the slave and master Wishbone ports
// Bound into the bus wrapper, engine status taken from its core
`timescale 1ns/1ns

module team_01_sva (
    input logic            clk_i,
    input logic            rst_i,
    input wb_pkg::wb_req_t mst_req_i,
    input wb_pkg::wb_rsp_t mst_rsp_i,
    input logic            wbs_ack_i,
    input logic            busy_i,
    input logic            done_i,
    input logic            irq_i
);

    int fails = 0;  // Failed assertions so far

    // Request frozen while waiting for ack
    hold_req: assert property (@(posedge clk_i) disable iff (rst_i)
        mst_req_i.stb && !mst_rsp_i.ack |=> $stable(mst_req_i))
        else begin
            fails++;
            $error("Master request changed before its ack");
        end

    stb_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
        mst_req_i.stb |-> mst_req_i.cyc)
        else begin
            fails++;
            $error("Master stb high without cyc");
        end

    ack_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        wbs_ack_i |=> !wbs_ack_i)
        else begin
            fails++;
            $error("Slave ack held longer than one cycle");
        end

    // Everything quiet once reset has been seen
    reset_idle: assert property (@(posedge clk_i)
        rst_i |=> !mst_req_i.cyc && !mst_req_i.stb && !mst_req_i.we &&
                  !wbs_ack_i && !busy_i && !done_i && !irq_i)
        else begin
            fails++;
            $error("Bus or status not idle after reset");
        end

endmodule

bind team_01_wb team_01_sva props (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .mst_req_i (mst_req_o),
    .mst_rsp_i (mst_rsp_i),
    .wbs_ack_i (wbs_rsp_o.ack),
    .busy_i    (busy),
    .done_i    (done),
    .irq_i     (irq_o)
);

// File: verification/team_01_tb.sv
// Testbench for the team 01 user area
// Clock, reset, LFSR stimulus, master-side memory model,
// reference memory and checks
`timescale 1ns/1ns
`include "team_01_consts.svh"

module team_01_tb;

    localparam logic [31:0] seed   = 32'haea2b4c8;
    localparam int          n_xfer = 12;  // Block transfers in the run

    logic                      wb_clk_i;
    logic                      rst_i;
    logic                      wbs_stb_i;
    logic                      wbs_cyc_i;
    logic                      wbs_we_i;
    wb_pkg::wb_sel_t           wbs_sel_i;
    wb_pkg::wb_dat_t           wbs_dat_i;
    wb_pkg::wb_adr_t           wbs_adr_i;
    logic                      wbs_ack_o;
    wb_pkg::wb_dat_t           wbs_dat_o;
    logic [127:0]              la_data_o;
    logic [`TEAM01_GPIO_W-1:0] gpio_o;
    logic [`TEAM01_GPIO_W-1:0] gpio_oeb_o;
    logic [2:0]                irq_o;
    wb_pkg::wb_dat_t           mst_dat_i;
    logic                      mst_ack_i;
    wb_pkg::wb_adr_t           mst_adr_o;
    wb_pkg::wb_dat_t           mst_dat_o;
    wb_pkg::wb_sel_t           mst_sel_o;
    logic                      mst_we_o;
    logic                      mst_stb_o;
    logic                      mst_cyc_o;

    logic [31:0]     stim_lfsr;                    // Config stream
    logic [31:0]     wait_lfsr;                    // Wait-state stream
    int              errors      = 0;
    int              checks      = 0;
    int              cycles      = 0;
    int              cycle_limit = 2000;           // Grows by 50 per word
    int              reads_seen;                   // Master beats in one run
    int              writes_seen;
    int              lens [n_xfer];
    wb_pkg::wb_dat_t regs [0:7];                   // Slave register model
    wb_pkg::wb_dat_t mem [wb_pkg::wb_adr_t];       // Seen by the DUT
    wb_pkg::wb_dat_t ref_mem [wb_pkg::wb_adr_t];   // Expected contents

    team_01_wrapper uut (.la_data_i('0), .la_oenb_i('1), .gpio_i('0), .*);

    initial begin : clock
        wb_clk_i = 1'b0;
        forever #20 wb_clk_i = ~wb_clk_i;  // 40 ns period
    end

    // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], st[0]};  // One step per bit
            st  = lfsr_next(st);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] exp_val,
                               input logic [63:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("FAIL %0t ns %s expected %h actual %h", $time, name, exp_val, act_val);
        end
    endtask

    // Unwritten memory differs for every address bit
    function automatic wb_pkg::wb_dat_t blank_word(input wb_pkg::wb_adr_t a);
        return a ^ {a[7:0], a[31:8]} ^ 32'h6b3d_91c5;
    endfunction

    function automatic wb_pkg::wb_dat_t mem_word(input wb_pkg::wb_adr_t a);
        return mem.exists(a) ? mem[a] : blank_word(a);
    endfunction

    function automatic wb_pkg::wb_dat_t ref_word(input wb_pkg::wb_adr_t a);
        return ref_mem.exists(a) ? ref_mem[a] : blank_word(a);
    endfunction

    // Bits that a register keeps by word index
    function automatic wb_pkg::wb_dat_t reg_mask(input logic [2:0] idx);
        case (idx)
            3'd0:             return 32'h0000_0006;  // fill and irq enable
            3'd3:             return 32'h0000_ffff;  // LEN
            3'd1, 3'd2, 3'd4: return 32'hffff_ffff;
            default:          return 32'h0;
        endcase
    endfunction

    // Slave cycle that returns 2 ns after the ack edge
    task automatic bus_access(input logic we, input logic [4:0] ofs, input wb_pkg::wb_dat_t dat,
                              input wb_pkg::wb_sel_t sel, output wb_pkg::wb_dat_t rdat);
        int n;
        wbs_adr_i = `TEAM01_BASE + {27'd0, ofs};
        wbs_dat_i = dat;
        wbs_sel_i = sel;
        wbs_we_i  = we;
        wbs_cyc_i = 1'b1;
        wbs_stb_i = 1'b1;
        n = 0;
        do begin
            @(posedge wb_clk_i);
            #2;
            n++;
        end while (!wbs_ack_o && n < 16);
        if (!wbs_ack_o) begin
            errors++;
            $display("Slave cycle to offset %h was never acknowledged", ofs);
        end
        rdat      = wbs_dat_o;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
    endtask

    task automatic reg_write(input logic [4:0] ofs, input wb_pkg::wb_dat_t dat,
                             input wb_pkg::wb_sel_t sel);
        wb_pkg::wb_dat_t lanes;
        wb_pkg::wb_dat_t unused;
        lanes = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        bus_access(1'b1, ofs, dat, sel, unused);
        regs[ofs[4:2]] = ((regs[ofs[4:2]] & ~lanes) | (dat & lanes)) & reg_mask(ofs[4:2]);
    endtask

    task automatic reg_read(input logic [4:0] ofs, output wb_pkg::wb_dat_t val);
        bus_access(1'b0, ofs, '0, '0, val);
    endtask

    task automatic check_reg(input logic [4:0] ofs);
        wb_pkg::wb_dat_t val;
        reg_read(ofs, val);
        check_value($sformatf("reg[%h]", ofs), regs[ofs[4:2]], val);
    endtask

    task automatic sweep_regs();
        check_reg(`TEAM01_REG_CTRL);
        check_reg(`TEAM01_REG_SRC);
        check_reg(`TEAM01_REG_DST);
        check_reg(`TEAM01_REG_LEN);
        check_reg(`TEAM01_REG_PAT);
        check_reg(5'h1C);  // Unmapped
        check_reg(5'h1E);
    endtask

    // Random writes with random byte selects and a readback of each
    task automatic reg_test();
        logic [31:0] r;
        logic [31:0] dat;
        logic [2:0]  idx;
        for (int i = 0; i < 24; i++) begin
            take_bits(stim_lfsr, 3, r);
            idx = (r[2:0] > 3'd4) ? r[2:0] - 3'd4 : r[2:0];  // CTRL to PAT
            take_bits(stim_lfsr, 32, dat);
            take_bits(stim_lfsr, 4, r);
            if (idx == 3'd0) begin
                dat[0] = 1'b0;  // No start here
            end
            reg_write({idx, 2'b00}, dat, r[3:0]);
            check_reg({idx, 2'b00});
        end
        sweep_regs();
    endtask

    // Whole memory against the reference in both directions
    task automatic compare_memory();
        foreach (mem[a]) begin
            check_value($sformatf("mem[%h]", a), ref_word(a), mem[a]);
        end
        foreach (ref_mem[a]) begin
            if (!mem.exists(a)) begin
                check_value($sformatf("mem[%h]", a), ref_mem[a], blank_word(a));
            end
        end
    endtask

    task automatic run_transfer(input int idx);
        logic [31:0]     r;
        logic            fill;
        logic            irq_en;
        int              len;
        wb_pkg::wb_adr_t src;
        wb_pkg::wb_adr_t dst;
        wb_pkg::wb_dat_t pat;
        wb_pkg::wb_dat_t stat;
        wb_pkg::wb_dat_t val;
        len = lens[idx];
        take_bits(stim_lfsr, 2, r);
        fill   = r[0];
        irq_en = r[1];
        take_bits(stim_lfsr, 10, r);
        src = 32'h1000_0000 + {r[9:0], 2'b00};  // Source and destination never overlap
        take_bits(stim_lfsr, 10, r);
        dst = 32'h2000_0000 + {r[9:0], 2'b00};
        take_bits(stim_lfsr, 32, pat);
        reg_write(`TEAM01_REG_SRC, src, 4'hf);
        reg_write(`TEAM01_REG_DST, dst, 4'hf);
        reg_write(`TEAM01_REG_LEN, len, 4'hf);
        reg_write(`TEAM01_REG_PAT, pat, 4'hf);
        for (int k = 0; k < len; k++) begin
            ref_mem[dst + 4 * k] = fill ? pat : ref_word(src + 4 * k);
        end
        reads_seen  = 0;
        writes_seen = 0;
        reg_write(`TEAM01_REG_CTRL, {29'd0, irq_en, fill, 1'b1}, 4'hf);
        @(posedge wb_clk_i);
        #2;
        check_value("gpio_o[0]", len != 0, gpio_o[0]);  // Busy one edge after start
        check_value("irq_o[0]", 0, irq_o[0]);          // Cleared by the start
        if (len >= 6) begin
            // New target and a second start while busy leave the first setup
            reg_write(`TEAM01_REG_DST, dst + 32'h0001_0000, 4'hf);
            reg_write(`TEAM01_REG_CTRL, {29'd0, irq_en, fill, 1'b1}, 4'hf);
        end
        do begin
            reg_read(`TEAM01_REG_STAT, stat);
        end while (!stat[1]);
        check_value("STAT", 32'h2, stat);
        reg_read(`TEAM01_REG_CNT, val);
        check_value("CNT", len, val);
        check_value("la_data_o[63:0]", len, la_data_o[63:0]);
        check_value("la_data_o[127:64]", 0, la_data_o[127:64]);
        check_value("gpio_o", 0, gpio_o);
        check_value("irq_o", irq_en, irq_o);
        check_value("master reads", fill ? 0 : len, reads_seen);  // Fill never reads
        check_value("master writes", len, writes_seen);
        compare_memory();
    endtask

    // Memory slave on the master port with 0 to 3 wait states per beat
    initial begin : mem_slave
        logic [31:0] r;
        int          waits;
        logic        pending;
        mst_ack_i = 1'b0;
        mst_dat_i = '0;
        wait_lfsr = seed;
        pending   = 1'b0;
        waits     = 0;
        forever begin
            @(posedge wb_clk_i);
            #2;
            mst_ack_i = 1'b0;  // Last beat taken on this edge
            if (mst_cyc_o && mst_stb_o) begin
                if (!pending) begin
                    take_bits(wait_lfsr, 2, r);
                    waits   = r[1:0];
                    pending = 1'b1;
                end
                if (waits > 0) begin
                    waits--;
                end else begin
                    check_value("mst_sel_o", 4'hf, mst_sel_o);
                    if (mst_we_o) begin
                        mem[mst_adr_o] = mst_dat_o;
                        writes_seen++;
                    end else begin
                        mst_dat_i = mem_word(mst_adr_o);
                        reads_seen++;
                    end
                    mst_ack_i = 1'b1;
                    pending   = 1'b0;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles <= cycle_limit) begin
            @(posedge wb_clk_i);
            cycles++;
        end
        $display("Timeout, run still going after %0d cycles", cycles);
        $display("test failed");
        $finish;
    end

    initial begin : main
        logic [31:0]     r;
        wb_pkg::wb_dat_t val;
        rst_i     = 1'b1;
        wbs_stb_i = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = '0;
        wbs_dat_i = '0;
        wbs_adr_i = '0;
        stim_lfsr = seed;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        for (int i = 0; i < n_xfer; i++) begin
            take_bits(stim_lfsr, 4, r);
            lens[i] = r[3:0];
            if (i == n_xfer / 2) begin
                lens[i] = 0;  // Empty run without bus cycles
            end
            cycle_limit = cycle_limit + 50 * lens[i];
        end
        repeat (16) @(posedge wb_clk_i);
        #2;
        rst_i = 1'b0;
        check_value("gpio_o", 0, gpio_o);
        check_value("gpio_oeb_o", 38'h3f_ffff_fffe, gpio_oeb_o);  // Only pin 0 drives
        check_value("irq_o", 0, irq_o);
        check_value("mst_cyc_o", 0, mst_cyc_o);
        check_value("wbs_ack_o", 0, wbs_ack_o);
        reg_read(`TEAM01_REG_STAT, val);
        check_value("STAT", 0, val);
        reg_test();
        for (int i = 0; i < n_xfer; i++) begin
            run_transfer(i);
        end
        sweep_regs();
        errors = errors + uut.team_01_wb.props.fails;
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, uut.team_01_wb.props.fails);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+source
source/wb_pkg.sv
source/xfer_pkg.sv
source/team_01.sv
source/team_01_wb.sv
source/team_01_wrapper.sv
verification/team_01_sva.sv
verification/team_01_tb.sv

// File: Bender.yml
package:
  name: team_01

sources:
  - include_dirs:
      - source
    files:
      - source/wb_pkg.sv
      - source/xfer_pkg.sv
      - source/team_01.sv
      - source/team_01_wb.sv
      - source/team_01_wrapper.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/team_01_sva.sv
      - verification/team_01_tb.sv
